/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
exit 1

/* sources.f */
src/rv_pkg.sv
src/pipe_ifs.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/hazard_unit.sv
src/core_top.sv
testbench/core_properties.sv
testbench/core_tb.sv

/* src/core_top.sv */
`timescale 1ns/100ps

module core_top (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::xlen-1:0] iad,
    input  logic [rv_pkg::xlen-1:0] idt,
    input  logic                    acki_n,
    output logic [rv_pkg::xlen-1:0] dad,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    mreq,
    output logic                    write,
    input  logic                    ackd_n
);

    logic [rv_pkg::xlen-1:0] ifid_pc;
    logic [rv_pkg::xlen-1:0] ifid_instr;
    logic [rv_pkg::xlen-1:0] branch_target;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [rv_pkg::xlen-1:0] rs1_val;
    logic [rv_pkg::xlen-1:0] rs2_val;
    logic                    wb_en;
    logic [4:0]              wb_rd;
    logic [rv_pkg::xlen-1:0] wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    hazard_if hz ();

    fetch_stage u_fetch (
        .clk(clk), .rst(rst), .idt(idt), .hz(hz),
        .branch_target(branch_target),
        .iad(iad), .ifid_pc(ifid_pc), .ifid_instr(ifid_instr)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .ifid_pc(ifid_pc), .ifid_instr(ifid_instr),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .rs1(rs1), .rs2(rs2),
        .id_ex(id_ex), .hz(hz)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .wb_data(wb_data), .branch_target(branch_target),
        .id_ex(id_ex), .ex_mem(ex_mem), .hz(hz)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .rst(rst), .dmem_rdata(dmem_rdata), .ackd_n(ackd_n),
        .dad(dad), .dmem_wdata(dmem_wdata), .mreq(mreq), .write(write),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .ex_mem(ex_mem), .interlock(hz.interlock)
    );

    hazard_unit u_hazard (
        .acki_n(acki_n), .ackd_n(ackd_n), .mreq(mreq),
        .wb_rd(wb_rd), .wb_en(wb_en),
        .mem_rd(ex_mem.rd), .mem_reg_write(ex_mem.reg_write),
        .hz(hz)
    );

endmodule

/* src/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rv_pkg::xlen-1:0] ifid_pc,
    input  logic [rv_pkg::xlen-1:0] ifid_instr,
    input  logic [rv_pkg::xlen-1:0] rs1_val,
    input  logic [rv_pkg::xlen-1:0] rs2_val,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    id_ex_if.decode                 id_ex,
    hazard_if.decode                hz
);
    import rv_pkg::*;

    opcode_e         opc;
    logic [4:0]      rd;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    logic            reg_write;
    logic            uses_rs2;

    assign opc       = opcode_e'(ifid_instr[6:0]);
    assign rd        = ifid_instr[11:7];
    assign funct3    = ifid_instr[14:12];
    assign rs1       = ifid_instr[19:15];
    assign rs2       = ifid_instr[24:20];
    assign funct7_b5 = ifid_instr[30];

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        reg_write = 1'b0;
        uses_rs2  = 1'b0;
        case (opc)
            OPC_OP: begin
                uses_rs2  = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7_b5 ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OPC_OP_IMM: begin
                imm       = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
                reg_write = 1'b1;
                case (funct3)
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OPC_LOAD: begin
                imm       = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
                reg_write = 1'b1;
            end
            OPC_STORE: begin
                imm      = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
                uses_rs2 = 1'b1;
            end
            OPC_BRANCH: begin
                imm = {{20{ifid_instr[31]}}, ifid_instr[7], ifid_instr[30:25],
                       ifid_instr[11:8], 1'b0};
                uses_rs2 = 1'b1;
            end
            OPC_LUI: begin
                imm       = {ifid_instr[31:12], 12'b0};
                alu_op    = ALU_PASS_B;
                reg_write = 1'b1;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

    // Unused sources never cause a load-use stall
    assign hz.id_rs1 = (opc == OPC_LUI) ? 5'd0 : rs1;
    assign hz.id_rs2 = uses_rs2 ? rs2 : 5'd0;

    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.opcode    <= OPC_OP_IMM;
            id_ex.alu_op    <= ALU_ADD;
            id_ex.rd        <= 5'd0;
            id_ex.reg_write <= 1'b0;
        end else if (!hz.interlock) begin
            if (hz.stall || hz.flush) begin
                id_ex.opcode    <= OPC_OP_IMM;
                id_ex.alu_op    <= ALU_ADD;
                id_ex.rd        <= 5'd0;
                id_ex.reg_write <= 1'b0;
            end else begin
                id_ex.opcode    <= opc;
                id_ex.alu_op    <= alu_op;
                id_ex.rd        <= rd;
                id_ex.reg_write <= reg_write && rd != 5'd0;
            end
            id_ex.pc      <= ifid_pc;
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
            id_ex.imm     <= imm;
            id_ex.rs1     <= rs1;
            id_ex.rs2     <= rs2;
            id_ex.funct3  <= funct3;
        end
    end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rv_pkg::xlen-1:0] wb_data,
    output logic [rv_pkg::xlen-1:0] branch_target,
    id_ex_if.execute                id_ex,
    ex_mem_if.execute               ex_mem,
    hazard_if.execute               hz
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_fwd;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic            is_load;
    logic            is_store;
    logic            taken;

    function automatic logic [xlen-1:0] pick(input fwd_sel_e sel, input logic [xlen-1:0] reg_val);
        case (sel)
            FWD_MEM: return ex_mem.alu_result;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    assign op_a    = pick(hz.fwd_a, id_ex.rs1_val);
    assign rs2_fwd = pick(hz.fwd_b, id_ex.rs2_val);
    assign op_b    = (id_ex.opcode == OPC_OP || id_ex.opcode == OPC_BRANCH) ? rs2_fwd : id_ex.imm;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // BEQ and BNE only
    always_comb begin
        taken = 1'b0;
        if (id_ex.opcode == OPC_BRANCH) begin
            if (id_ex.funct3 == 3'b000) begin
                taken = (op_a == rs2_fwd);
            end else if (id_ex.funct3 == 3'b001) begin
                taken = (op_a != rs2_fwd);
            end
        end
    end

    assign branch_target = id_ex.pc + id_ex.imm;
    assign is_load       = (id_ex.opcode == OPC_LOAD);
    assign is_store      = (id_ex.opcode == OPC_STORE);

    assign hz.ex_rs1          = id_ex.rs1;
    assign hz.ex_rs2          = id_ex.rs2;
    assign hz.ex_rd           = id_ex.rd;
    assign hz.ex_mem_read     = is_load;
    assign hz.ex_reg_write    = id_ex.reg_write;
    assign hz.ex_branch_taken = taken;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.rd        <= 5'd0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else if (!hz.interlock) begin
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= is_load;
            ex_mem.mem_write  <= is_store;
            ex_mem.alu_result <= alu_out;
            ex_mem.store_data <= rs2_fwd;
        end
    end

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rv_pkg::xlen-1:0] idt,
    hazard_if.fetch                 hz,
    input  logic [rv_pkg::xlen-1:0] branch_target,
    output logic [rv_pkg::xlen-1:0] iad,
    output logic [rv_pkg::xlen-1:0] ifid_pc,
    output logic [rv_pkg::xlen-1:0] ifid_instr
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;

    assign iad = pc;

    always_comb begin
        if (hz.flush) begin
            pc_next = branch_target;
        end else if (hz.stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (!hz.interlock) begin
            pc <= pc_next;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (rst) begin
            ifid_instr <= nop_instr;
        end else if (!hz.interlock) begin
            if (hz.flush) begin
                ifid_instr <= nop_instr;
            end else if (!hz.stall) begin
                ifid_instr <= idt;
                ifid_pc    <= pc;
            end
        end
    end

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
    input  logic       acki_n,
    input  logic       ackd_n,
    input  logic       mreq,
    input  logic [4:0] wb_rd,
    input  logic       wb_en,
    input  logic [4:0] mem_rd,
    input  logic       mem_reg_write,
    hazard_if.hazard   hz
);
    import rv_pkg::*;

    function automatic fwd_sel_e fwd_for(input logic [4:0] src);
        if (mem_reg_write && mem_rd != 5'd0 && mem_rd == src) begin
            return FWD_MEM;
        end else if (wb_en && wb_rd != 5'd0 && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign hz.fwd_a = fwd_for(hz.ex_rs1);
    assign hz.fwd_b = fwd_for(hz.ex_rs2);

    // Load in EX feeding the instruction in ID
    assign hz.stall = hz.ex_mem_read && hz.ex_reg_write && hz.ex_rd != 5'd0
                   && (hz.ex_rd == hz.id_rs1 || hz.ex_rd == hz.id_rs2);

    assign hz.flush = hz.ex_branch_taken;

    assign hz.interlock = acki_n | (mreq & ackd_n);

endmodule

/* src/mem_wb_stage.sv */
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    input  logic                    ackd_n,
    output logic [rv_pkg::xlen-1:0] dad,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    mreq,
    output logic                    write,
    output logic                    wb_en,
    output logic [4:0]              wb_rd,
    output logic [rv_pkg::xlen-1:0] wb_data,
    ex_mem_if.memory                ex_mem,
    input  logic                    interlock
);
    import rv_pkg::*;

    logic            wb_valid;
    logic            load_ready;
    logic [xlen-1:0] mem_result;

    // Data bus straight from EX/MEM
    assign dad        = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign mreq       = ex_mem.mem_read | ex_mem.mem_write;
    assign write      = ex_mem.mem_write;

    assign load_ready = ex_mem.mem_read & ~ackd_n;
    assign mem_result = load_ready ? dmem_rdata : ex_mem.alu_result;

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_rd    <= 5'd0;
        end else if (!interlock) begin
            wb_valid <= ex_mem.reg_write;
            wb_rd    <= ex_mem.rd;
            wb_data  <= mem_result;
        end
    end

    // Write only in the cycle the pipeline moves on
    assign wb_en = wb_valid & ~interlock;

endmodule

/* src/pipe_ifs.sv */
`timescale 1ns/100ps

interface id_ex_if;
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    alu_op_e         alu_op;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            reg_write;

    modport decode (
        output pc, rs1_val, rs2_val, imm, rs1, rs2, rd, alu_op, opcode, funct3, reg_write
    );
    modport execute (
        input pc, rs1_val, rs2_val, imm, rs1, rs2, rd, alu_op, opcode, funct3, reg_write
    );
endinterface

interface ex_mem_if;
    import rv_pkg::*;

    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] store_data;
    logic [4:0]      rd;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;

    modport execute (output alu_result, store_data, rd, reg_write, mem_read, mem_write);
    modport memory (input alu_result, store_data, rd, reg_write, mem_read, mem_write);
endinterface

interface hazard_if;
    import rv_pkg::*;

    logic       stall;
    logic       flush;
    logic       interlock;
    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;
    logic [4:0] id_rs1;
    logic [4:0] id_rs2;
    // EX sources are needed to pick the forwarding selects
    logic [4:0] ex_rs1;
    logic [4:0] ex_rs2;
    logic [4:0] ex_rd;
    logic       ex_mem_read;
    logic       ex_branch_taken;
    logic       ex_reg_write;

    modport fetch (input stall, flush, interlock);
    modport decode (input stall, flush, interlock, output id_rs1, id_rs2);
    modport execute (
        input fwd_a, fwd_b, interlock,
        output ex_rs1, ex_rs2, ex_rd, ex_mem_read, ex_branch_taken, ex_reg_write
    );
    modport hazard (
        output stall, flush, interlock, fwd_a, fwd_b,
        input id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read, ex_branch_taken,
        ex_reg_write
    );
endinterface

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic                    wb_en,
    input  logic [4:0]              wb_rd,
    input  logic [rv_pkg::xlen-1:0] wb_data,
    output logic [rv_pkg::xlen-1:0] rs1_val,
    output logic [rv_pkg::xlen-1:0] rs2_val
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:31];

    // Same-cycle write shows through to the read
    function automatic logic [xlen-1:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wb_en && wb_rd == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    assign rs1_val = read_reg(rs1);
    assign rs2_val = read_reg(rs2);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

/* src/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

endpackage

/* testbench/core_properties.sv */
`timescale 1ns/100ps

module core_properties (
    input logic        clk,
    input logic        rst,
    input logic [31:0] iad,
    input logic [31:0] dad,
    input logic [31:0] dmem_wdata,
    input logic        mreq,
    input logic        write,
    input logic        ackd_n
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    write_needs_mreq: assert property (@(posedge clk) disable iff (rst) write |-> mreq)
        else begin
            $error("write asserted without mreq");
            fail_count++;
        end

    // Data bus frozen until the acknowledge arrives
    bus_held_while_waiting: assert property (@(posedge clk) disable iff (rst)
        (mreq && ackd_n) |=> ($stable(dad) && $stable(write) && $stable(dmem_wdata)))
        else begin
            $error("data bus changed while ackd_n was withheld");
            fail_count++;
        end

    iad_word_aligned: assert property (@(posedge clk) disable iff (rst) iad[1:0] == 2'b00)
        else begin
            $error("iad not word aligned");
            fail_count++;
        end

endmodule

bind core_top core_properties props (
    .clk(clk), .rst(rst), .iad(iad), .dad(dad), .dmem_wdata(dmem_wdata),
    .mreq(mreq), .write(write), .ackd_n(ackd_n)
);

/* testbench/core_tb.sv */
`timescale 1ns/100ps

module core_clock #(
    parameter int period = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end
endmodule

module core_tb;

    localparam int clk_period = 100;
    localparam int rom_words = 256;
    localparam int ram_words = 256;
    localparam int max_prog_len = 32;
    localparam int max_wait_run = 3;
    // Each pipeline advance takes at most max_wait_run + 1 cycles
    localparam int run_limit = (max_prog_len + 12) * (max_wait_run + 1);
    localparam int program_runs = 7;
    localparam int watchdog_cycles = program_runs * (run_limit + 8) + 100;
    localparam logic [31:0] lcg_seed = 32'h7c44;
    localparam logic [31:0] marker_addr = 32'h0000_03fc;
    localparam logic [31:0] first_fetch_addr = 32'h0000_0000;
    localparam logic [31:0] nop_word = 32'h0000_0013;

    // RV32I major opcodes
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui = 7'b0110111;

    logic        clk;
    logic        rst;
    logic [31:0] iad;
    logic [31:0] idt;
    logic        acki_n;
    logic [31:0] dad;
    logic [31:0] dmem_rdata;
    logic [31:0] dmem_wdata;
    logic        mreq;
    logic        write;
    logic        ackd_n;

    logic [31:0] rom [rom_words];
    logic [31:0] ram [ram_words];
    logic [7:0]  prog_len;
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic        marker_seen;
    logic        wait_mode;
    logic [31:0] lcg_state = lcg_seed;
    logic        wait_i;
    logic        wait_d;
    int          wait_run;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors_start;

    core_clock #(.period(clk_period)) clock_gen (.clk(clk));

    core_top dut (
        .clk(clk), .rst(rst), .iad(iad), .idt(idt), .acki_n(acki_n),
        .dad(dad), .dmem_rdata(dmem_rdata), .dmem_wdata(dmem_wdata),
        .mreq(mreq), .write(write), .ackd_n(ackd_n)
    );

    assign idt = rom[iad[9:2]];
    assign dmem_rdata = ram[dad[9:2]];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, opc_lui};
    endfunction

    // Data ack only lands in cycles where fetch also acks, so each transfer completes once
    always @(posedge clk) begin
        lcg_state = lcg_next(lcg_state);
        wait_i = lcg_state[16];
        wait_d = lcg_state[17] & lcg_state[18];
        if (!wait_mode || wait_run >= max_wait_run) begin
            acki_n <= 1'b0;
            ackd_n <= 1'b0;
            wait_run = 0;
        end else begin
            acki_n <= wait_i;
            ackd_n <= wait_i | wait_d;
            wait_run = (wait_i | wait_d) ? wait_run + 1 : 0;
        end
    end

    // Store log and RAM update
    always @(posedge clk) begin
        if (!rst && mreq && write && !ackd_n) begin
            if (dad == marker_addr) begin
                marker_seen = 1'b1;
            end else begin
                got_addr.push_back(dad);
                got_data.push_back(dmem_wdata);
            end
            ram[dad[9:2]] <= dmem_wdata;
        end
    end

    task automatic emit(input logic [31:0] instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("mismatch %s: got %h expected %h", what, got, exp);
            errors++;
        end
    endtask

    // Holds the core in reset while the next program is loaded
    task automatic start_program();
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < rom_words; i++) begin
            rom[i[7:0]] = nop_word;
        end
        for (int i = 0; i < ram_words; i++) begin
            ram[i[7:0]] = fill_word({i[29:0], 2'b00});
        end
        prog_len = 8'd0;
        got_addr.delete();
        got_data.delete();
        exp_addr.delete();
        exp_data.delete();
        marker_seen = 1'b0;
        test_errors_start = errors;
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("%s%s: %s", name, wait_mode ? " with wait states" : "",
                 (errors == test_errors_start) ? "ok" : "failed");
    endtask

    task automatic finish_program(input string name);
        int cycles;
        int n;
        emit(s_type(marker_addr[11:0], 5'd0, 5'd0));
        release_reset();
        cycles = 0;
        while (!marker_seen && cycles < run_limit) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (marker_seen) else begin
            $display("%s: no store to the marker address after %0d cycles", name, run_limit);
            errors++;
        end
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        check_word("store count", got_addr.size(), exp_addr.size());
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("dad of store %0d", i), got_addr[i], exp_addr[i]);
            check_word($sformatf("dmem_wdata of store %0d", i), got_data[i], exp_data[i]);
        end
        report_test(name);
    endtask

    task automatic reset_state_test();
        start_program();
        check_word("mreq in reset", {31'b0, mreq}, 32'd0);
        check_word("write in reset", {31'b0, write}, 32'd0);
        release_reset();
        @(negedge clk);
        check_word("iad", iad, first_fetch_addr);
        check_word("mreq", {31'b0, mreq}, 32'd0);
        check_word("write", {31'b0, write}, 32'd0);
        report_test("reset state");
    endtask

    task automatic alu_forwarding_test();
        logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9, r10, r11, r12;
        start_program();
        emit(u_type(20'h12345, 5'd1));
        emit(i_type(12'h678, 5'd1, 3'b000, 5'd2, opc_op_imm));
        emit(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        emit(s_type(12'h100, 5'd3, 5'd0));
        emit(r_type(7'h20, 5'd3, 5'd1, 3'b000, 5'd4));
        emit(i_type(12'hfff, 5'd4, 3'b100, 5'd5, opc_op_imm));
        emit(s_type(12'h104, 5'd5, 5'd0));
        emit(r_type(7'h00, 5'd2, 5'd4, 3'b010, 5'd6));
        emit(i_type(12'hffb, 5'd2, 3'b010, 5'd7, opc_op_imm));
        emit(r_type(7'h00, 5'd6, 5'd5, 3'b110, 5'd8));
        emit(r_type(7'h00, 5'd8, 5'd3, 3'b111, 5'd9));
        emit(r_type(7'h00, 5'd4, 5'd9, 3'b100, 5'd10));
        emit(i_type(12'h7f0, 5'd10, 3'b111, 5'd11, opc_op_imm));
        emit(i_type(12'h00f, 5'd11, 3'b110, 5'd12, opc_op_imm));
        emit(s_type(12'h108, 5'd6, 5'd0));
        emit(s_type(12'h10c, 5'd7, 5'd0));
        emit(s_type(12'h110, 5'd10, 5'd0));
        emit(s_type(12'h114, 5'd12, 5'd0));
        // Write to x0 must be dropped, also on the forwarding paths
        emit(i_type(12'h005, 5'd1, 3'b000, 5'd0, opc_op_imm));
        emit(r_type(7'h00, 5'd2, 5'd0, 3'b000, 5'd13));
        emit(s_type(12'h118, 5'd13, 5'd0));
        emit(s_type(12'h11c, 5'd0, 5'd0));
        r1 = 32'h1234_5000;
        r2 = r1 + 32'h678;
        r3 = r2 + r1;
        r4 = r1 - r3;
        r5 = r4 ^ 32'hffff_ffff;
        r6 = ($signed(r4) < $signed(r2)) ? 32'd1 : 32'd0;
        r7 = ($signed(r2) < -32'sd5) ? 32'd1 : 32'd0;
        r8 = r5 | r6;
        r9 = r3 & r8;
        r10 = r9 ^ r4;
        r11 = r10 & 32'h0000_07f0;
        r12 = r11 | 32'h0000_000f;
        expect_store(32'h100, r3);
        expect_store(32'h104, r5);
        expect_store(32'h108, r6);
        expect_store(32'h10c, r7);
        expect_store(32'h110, r10);
        expect_store(32'h114, r12);
        expect_store(32'h118, r2);
        expect_store(32'h11c, 32'd0);
        finish_program("alu forwarding");
    endtask

    task automatic load_use_test();
        start_program();
        emit(i_type(12'h040, 5'd0, 3'b000, 5'd1, opc_op_imm));
        emit(i_type(12'h123, 5'd0, 3'b000, 5'd4, opc_op_imm));
        emit(i_type(12'h008, 5'd1, 3'b010, 5'd2, opc_load));
        emit(r_type(7'h00, 5'd4, 5'd2, 3'b000, 5'd3));
        emit(s_type(12'h100, 5'd3, 5'd0));
        emit(i_type(12'h00c, 5'd1, 3'b010, 5'd5, opc_load));
        emit(s_type(12'h104, 5'd5, 5'd0));
        expect_store(32'h100, fill_word(32'h48) + 32'h123);
        expect_store(32'h104, fill_word(32'h4c));
        finish_program("load use");
    endtask

    task automatic branch_test();
        start_program();
        emit(i_type(12'h007, 5'd0, 3'b000, 5'd1, opc_op_imm));
        emit(i_type(12'h007, 5'd0, 3'b000, 5'd2, opc_op_imm));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));
        emit(s_type(12'h200, 5'd1, 5'd0));
        emit(b_type(13'd16, 5'd2, 5'd1, 3'b000));
        // Two flushed slots, then one skipped instruction
        emit(s_type(12'h204, 5'd1, 5'd0));
        emit(s_type(12'h208, 5'd2, 5'd0));
        emit(s_type(12'h20c, 5'd0, 5'd0));
        emit(i_type(12'h001, 5'd1, 3'b000, 5'd3, opc_op_imm));
        emit(s_type(12'h210, 5'd3, 5'd0));
        expect_store(32'h200, 32'd7);
        expect_store(32'h210, 32'd8);
        finish_program("branch");
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        acki_n = 1'b0;
        ackd_n = 1'b0;
        wait_mode = 1'b0;
        wait_run = 0;
        marker_seen = 1'b0;
        prog_len = 8'd0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors_start = 0;
        reset_state_test();
        alu_forwarding_test();
        load_use_test();
        branch_test();
        wait_mode = 1'b1;
        alu_forwarding_test();
        load_use_test();
        branch_test();
        check_word("property failures", dut.props.fail_count, 32'd0);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
